// ==== src.f ====
hdl/sram_ctrl_pkg.sv
hdl/sram_timing_regs.sv
hdl/sram_access_fsm.sv
hdl/sram_datapath.sv
hdl/sram_ctrl_top.sv
testbench/sram_model.sv
testbench/tb_sram_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench, then look for the failure marker in the log
verilator --binary --top-module tb_sram_ctrl -f src.f -o sim_sram_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_sram_ctrl > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }

// ==== testbench/tb_sram_ctrl.sv ====
module tb_sram_ctrl;

    localparam int TIMEOUT_CYCLES = 100;

    logic                             clk;
    logic                             rst_n;
    logic                             read_req;
    logic                             write_req;
    logic [sram_ctrl_pkg::ADDR_W-1:0] address;
    logic [sram_ctrl_pkg::DATA_W-1:0] write_data;
    logic [sram_ctrl_pkg::DATA_W-1:0] read_data;
    logic                             ready;
    logic                             cfg_wr;
    logic                             cfg_addr;
    logic [sram_ctrl_pkg::WAIT_W-1:0] cfg_wdata;
    logic [sram_ctrl_pkg::WAIT_W-1:0] cfg_rdata;
    logic [sram_ctrl_pkg::ADDR_W-1:0] sram_addr;
    wire  [sram_ctrl_pkg::DATA_W-1:0] sram_data;
    logic                             sram_ce_n;
    logic                             sram_oe_n;
    logic                             sram_we_n;

    // Mirror of the SRAM contents
    logic [sram_ctrl_pkg::DATA_W-1:0] ref_mem [0:2**sram_ctrl_pkg::ADDR_W-1];
    logic [31:0]                      rng_state = 32'd56;
    logic [sram_ctrl_pkg::WAIT_W-1:0] rd_wait_cfg = 4'd2;
    int                               errors = 0;
    int                               bus_errors = 0;

    sram_ctrl_top u_sram_ctrl_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_req   (read_req),
        .write_req  (write_req),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .ready      (ready),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .sram_addr  (sram_addr),
        .sram_data  (sram_data),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n)
    );

    sram_model u_sram_model (
        .addr (sram_addr),
        .data (sram_data),
        .ce_n (sram_ce_n),
        .oe_n (sram_oe_n),
        .we_n (sram_we_n)
    );

    always #20 clk = ~clk;

    // Strobe discipline, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (!sram_oe_n && !sram_we_n) begin
                bus_errors++;
                $display("Bus error at %0t: oe_n and we_n are low together", $time);
            end
            if ((!sram_oe_n || !sram_we_n) && sram_ce_n) begin
                bus_errors++;
                $display("Bus error at %0t: oe_n or we_n is low while ce_n is high", $time);
            end
        end
    end

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [sram_ctrl_pkg::DATA_W-1:0] fill_word(input int a);
        return 16'(a * 3) ^ 16'hc35a;
    endfunction

    task automatic check_data(input string name, input logic [sram_ctrl_pkg::DATA_W-1:0] exp,
                              input logic [sram_ctrl_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_wait(input string name, input logic [sram_ctrl_pkg::WAIT_W-1:0] exp,
                              input logic [sram_ctrl_pkg::WAIT_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            errors++;
            $display("Timeout at %0t: ready never came back high", $time);
        end
    endtask

    task automatic write_cfg(input logic sel, input logic [sram_ctrl_pkg::WAIT_W-1:0] val);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= sel;
        cfg_wdata <= val;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    task automatic read_cfg_check(input logic sel, input logic [sram_ctrl_pkg::WAIT_W-1:0] exp);
        @(posedge clk);
        cfg_addr <= sel;
        @(negedge clk);
        check_wait(sel ? "cfg_rdata(wr_wait)" : "cfg_rdata(rd_wait)", exp, cfg_rdata);
    endtask

    // One access; cycles counts edges from acceptance to ready high
    task automatic run_access(input logic rd, input logic wr,
                              input logic [sram_ctrl_pkg::ADDR_W-1:0] addr,
                              input logic [sram_ctrl_pkg::DATA_W-1:0] data,
                              output int cycles);
        wait_ready();
        @(posedge clk);
        read_req   <= rd;
        write_req  <= wr;
        address    <= addr;
        write_data <= data;
        @(posedge clk);
        read_req   <= 1'b0;
        write_req  <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!ready && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (!ready) begin
            errors++;
            $display("Timeout at %0t: access to address %h did not finish", $time, addr);
        end
    endtask

    task automatic test_reset();
        check_level("ready", 1'b1, ready);
        check_level("sram_ce_n", 1'b1, sram_ce_n);
        check_level("sram_oe_n", 1'b1, sram_oe_n);
        check_level("sram_we_n", 1'b1, sram_we_n);
        read_cfg_check(1'b0, 4'd2);
        read_cfg_check(1'b1, 4'd3);
    endtask

    task automatic test_write_read();
        logic [31:0]                      r;
        logic [sram_ctrl_pkg::ADDR_W-1:0] addr;
        logic [sram_ctrl_pkg::ADDR_W-1:0] other;
        logic [sram_ctrl_pkg::DATA_W-1:0] data;
        int                               cycles;
        for (int k = 0; k < 20; k++) begin
            r     = rand_next();
            addr  = r[30:16];
            other = addr + {7'd0, r[7:0]} + 15'd1;
            r     = rand_next();
            data  = r[31:16];
            run_access(1'b0, 1'b1, addr, data, cycles);
            ref_mem[addr] = data;
            run_access(1'b1, 1'b0, addr, '0, cycles);
            check_data("read_data", ref_mem[addr], read_data);
            // Neighbour keeps its own word
            run_access(1'b1, 1'b0, other, '0, cycles);
            check_data("read_data", ref_mem[other], read_data);
        end
    endtask

    task automatic test_latency();
        logic [sram_ctrl_pkg::WAIT_W-1:0] vals [0:2];
        logic [sram_ctrl_pkg::WAIT_W-1:0] wr_val;
        logic [31:0]                      r;
        logic [sram_ctrl_pkg::ADDR_W-1:0] addr;
        logic [sram_ctrl_pkg::DATA_W-1:0] data;
        int                               cycles;
        vals[0] = 4'd0;
        vals[1] = 4'd5;
        vals[2] = 4'd15;
        for (int k = 0; k < 3; k++) begin
            // Read and write counts differ in every round
            wr_val = vals[(k + 1) % 3];
            write_cfg(1'b0, vals[k]);
            write_cfg(1'b1, wr_val);
            read_cfg_check(1'b0, vals[k]);
            read_cfg_check(1'b1, wr_val);
            rd_wait_cfg = vals[k];
            r    = rand_next();
            addr = r[30:16];
            data = r[15:0];
            run_access(1'b0, 1'b1, addr, data, cycles);
            ref_mem[addr] = data;
            check_latency("write latency", int'(wr_val) + 3, cycles);
            run_access(1'b1, 1'b0, addr, '0, cycles);
            check_latency("read latency", int'(vals[k]) + 2, cycles);
            check_data("read_data", ref_mem[addr], read_data);
        end
    endtask

    task automatic test_read_priority();
        logic [31:0]                      r;
        logic [sram_ctrl_pkg::ADDR_W-1:0] addr;
        int                               cycles;
        r    = rand_next();
        addr = r[30:16];
        // Both strobes up; the write must be dropped
        run_access(1'b1, 1'b1, addr, ~ref_mem[addr], cycles);
        check_latency("read latency", int'(rd_wait_cfg) + 2, cycles);
        check_data("read_data", ref_mem[addr], read_data);
        run_access(1'b1, 1'b0, addr, '0, cycles);
        check_data("read_data", ref_mem[addr], read_data);
    endtask

    initial begin
        clk = 1'b0;
        rst_n      <= 1'b0;
        read_req   <= 1'b0;
        write_req  <= 1'b0;
        address    <= '0;
        write_data <= '0;
        cfg_wr     <= 1'b0;
        cfg_addr   <= 1'b0;
        cfg_wdata  <= '0;
        for (int i = 0; i < 2**sram_ctrl_pkg::ADDR_W; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_ready();
        test_reset();
        test_write_read();
        test_latency();
        test_read_priority();
        $display("Checks done: %0d errors, %0d bus errors", errors, bus_errors);
        if (errors == 0 && bus_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/sram_model.sv ====
module sram_model (
    input  logic [sram_ctrl_pkg::ADDR_W-1:0] addr,
    inout  wire  [sram_ctrl_pkg::DATA_W-1:0] data,
    input  logic                             ce_n,
    input  logic                             oe_n,
    input  logic                             we_n
);

    logic [sram_ctrl_pkg::DATA_W-1:0] mem [0:2**sram_ctrl_pkg::ADDR_W-1];
    logic                             drive;

    // Every word starts with a value tied to its full address
    initial begin
        for (int i = 0; i < 2**sram_ctrl_pkg::ADDR_W; i++) begin
            mem[i] = 16'(i * 3) ^ 16'hc35a;
        end
    end

    // Write completes on the rising edge of we_n
    always @(posedge we_n) begin
        if (!ce_n)
            mem[addr] <= data;
    end

    assign drive = !ce_n && !oe_n && we_n;
    assign data  = drive ? mem[addr] : {sram_ctrl_pkg::DATA_W{1'bz}};

endmodule

// ==== hdl/sram_ctrl_top.sv ====
module sram_ctrl_top (
    input  logic                             clk,
    input  logic                             rst_n,

    // CPU port
    input  logic                             read_req,
    input  logic                             write_req,
    input  logic [sram_ctrl_pkg::ADDR_W-1:0] address,
    input  logic [sram_ctrl_pkg::DATA_W-1:0] write_data,
    output logic [sram_ctrl_pkg::DATA_W-1:0] read_data,
    output logic                             ready,

    // Config port
    input  logic                             cfg_wr,
    input  logic                             cfg_addr,
    input  logic [sram_ctrl_pkg::WAIT_W-1:0] cfg_wdata,
    output logic [sram_ctrl_pkg::WAIT_W-1:0] cfg_rdata,

    // SRAM pins
    output logic [sram_ctrl_pkg::ADDR_W-1:0] sram_addr,
    inout  wire  [sram_ctrl_pkg::DATA_W-1:0] sram_data,
    output logic                             sram_ce_n,
    output logic                             sram_oe_n,
    output logic                             sram_we_n
);

    sram_ctrl_pkg::sram_timing_t timing;
    sram_ctrl_pkg::sram_ctl_t    ctl;

    sram_timing_regs u_timing_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .timing    (timing)
    );

    sram_access_fsm u_access_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .read_req  (read_req),
        .write_req (write_req),
        .timing    (timing),
        .ctl       (ctl),
        .ready     (ready)
    );

    sram_datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .ctl        (ctl),
        .sram_addr  (sram_addr),
        .sram_data  (sram_data),
        .sram_ce_n  (sram_ce_n),
        .sram_oe_n  (sram_oe_n),
        .sram_we_n  (sram_we_n)
    );

endmodule

// ==== hdl/sram_datapath.sv ====
module sram_datapath (
    input  logic                             clk,
    input  logic                             rst_n,

    // CPU side
    input  logic [sram_ctrl_pkg::ADDR_W-1:0] address,
    input  logic [sram_ctrl_pkg::DATA_W-1:0] write_data,
    output logic [sram_ctrl_pkg::DATA_W-1:0] read_data,

    // Steering from the sequencer
    input  sram_ctrl_pkg::sram_ctl_t         ctl,

    // SRAM pins
    output logic [sram_ctrl_pkg::ADDR_W-1:0] sram_addr,
    inout  wire  [sram_ctrl_pkg::DATA_W-1:0] sram_data,
    output logic                             sram_ce_n,
    output logic                             sram_oe_n,
    output logic                             sram_we_n
);

    logic [sram_ctrl_pkg::ADDR_W-1:0] addr_q;
    logic [sram_ctrl_pkg::DATA_W-1:0] wdata_q;
    logic [sram_ctrl_pkg::DATA_W-1:0] rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
        end else begin
            if (ctl.latch_addr)
                addr_q <= address;
            if (ctl.latch_data)
                wdata_q <= write_data;
            // Bus sampled at the end of the capture cycle
            if (ctl.latch_read)
                rdata_q <= sram_data;
        end
    end

    assign sram_addr = addr_q;
    assign read_data = rdata_q;

    // Only write states drive the bus
    assign sram_data = ctl.drive_data_en ? wdata_q : {sram_ctrl_pkg::DATA_W{1'bz}};

    assign sram_ce_n = ctl.ce_n;
    assign sram_oe_n = ctl.oe_n;
    assign sram_we_n = ctl.we_n;

endmodule

// ==== hdl/sram_access_fsm.sv ====
module sram_access_fsm (
    input  logic                        clk,
    input  logic                        rst_n,

    // CPU requests
    input  logic                        read_req,
    input  logic                        write_req,

    // Programmed wait states
    input  sram_ctrl_pkg::sram_timing_t timing,

    // Datapath steering and SRAM strobes
    output sram_ctrl_pkg::sram_ctl_t    ctl,
    output logic                        ready
);

    sram_ctrl_pkg::access_state_t state_q;
    sram_ctrl_pkg::access_state_t state_next;
    sram_ctrl_pkg::sram_timing_t  timing_q;
    logic [sram_ctrl_pkg::WAIT_W-1:0] cnt_q;
    logic [sram_ctrl_pkg::WAIT_W-1:0] cnt_next;
    logic accept;
    logic rd_next;
    logic ce_n_q;
    logic oe_n_q;
    logic we_n_q;

    assign ready  = (state_q == sram_ctrl_pkg::IDLE);
    assign accept = ready && (read_req || write_req);

    always_comb begin
        state_next = state_q;
        cnt_next   = cnt_q;
        case (state_q)
            sram_ctrl_pkg::IDLE: begin
                // Read wins when both are requested
                if (read_req)
                    state_next = sram_ctrl_pkg::RD_SETUP;
                else if (write_req)
                    state_next = sram_ctrl_pkg::WR_SETUP;
            end
            sram_ctrl_pkg::RD_SETUP: begin
                if (timing_q.rd_wait == '0) begin
                    state_next = sram_ctrl_pkg::RD_CAPTURE;
                end else begin
                    state_next = sram_ctrl_pkg::RD_WAIT;
                    cnt_next   = timing_q.rd_wait - 1'b1;
                end
            end
            sram_ctrl_pkg::RD_WAIT: begin
                if (cnt_q == '0)
                    state_next = sram_ctrl_pkg::RD_CAPTURE;
                else
                    cnt_next = cnt_q - 1'b1;
            end
            sram_ctrl_pkg::RD_CAPTURE: state_next = sram_ctrl_pkg::IDLE;
            sram_ctrl_pkg::WR_SETUP: begin
                // Pulse lasts wr_wait + 1 cycles
                state_next = sram_ctrl_pkg::WR_PULSE;
                cnt_next   = timing_q.wr_wait;
            end
            sram_ctrl_pkg::WR_PULSE: begin
                if (cnt_q == '0)
                    state_next = sram_ctrl_pkg::WR_HOLD;
                else
                    cnt_next = cnt_q - 1'b1;
            end
            sram_ctrl_pkg::WR_HOLD: state_next = sram_ctrl_pkg::IDLE;
            default: state_next = sram_ctrl_pkg::IDLE;
        endcase
    end

    assign rd_next = (state_next == sram_ctrl_pkg::RD_SETUP) ||
                     (state_next == sram_ctrl_pkg::RD_WAIT)  ||
                     (state_next == sram_ctrl_pkg::RD_CAPTURE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= sram_ctrl_pkg::IDLE;
            cnt_q   <= '0;
            ce_n_q  <= 1'b1;
            oe_n_q  <= 1'b1;
            we_n_q  <= 1'b1;
        end else begin
            state_q <= state_next;
            cnt_q   <= cnt_next;
            // Strobes registered alongside the state so they track it exactly
            ce_n_q  <= (state_next == sram_ctrl_pkg::IDLE);
            oe_n_q  <= !rd_next;
            we_n_q  <= (state_next != sram_ctrl_pkg::WR_PULSE);
        end
    end

    // Timing snapshot, later config writes hit the next access
    always_ff @(posedge clk) begin
        if (accept)
            timing_q <= timing;
    end

    assign ctl.latch_addr    = accept;
    assign ctl.latch_data    = accept && !read_req;
    assign ctl.latch_read    = (state_q == sram_ctrl_pkg::RD_CAPTURE);
    assign ctl.drive_data_en = (state_q == sram_ctrl_pkg::WR_SETUP) ||
                               (state_q == sram_ctrl_pkg::WR_PULSE) ||
                               (state_q == sram_ctrl_pkg::WR_HOLD);
    assign ctl.ce_n          = ce_n_q;
    assign ctl.oe_n          = oe_n_q;
    assign ctl.we_n          = we_n_q;

endmodule

// ==== hdl/sram_timing_regs.sv ====
module sram_timing_regs (
    input  logic                             clk,
    input  logic                             rst_n,

    // Config port
    input  logic                             cfg_wr,
    input  logic                             cfg_addr,
    input  logic [sram_ctrl_pkg::WAIT_W-1:0] cfg_wdata,
    output logic [sram_ctrl_pkg::WAIT_W-1:0] cfg_rdata,

    // Wait-state counts to the sequencer
    output sram_ctrl_pkg::sram_timing_t      timing
);

    sram_ctrl_pkg::sram_timing_t regs_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q.rd_wait <= sram_ctrl_pkg::RD_WAIT_RST;
            regs_q.wr_wait <= sram_ctrl_pkg::WR_WAIT_RST;
        end else if (cfg_wr) begin
            case (cfg_addr)
                sram_ctrl_pkg::CFG_RD_WAIT: regs_q.rd_wait <= cfg_wdata;
                sram_ctrl_pkg::CFG_WR_WAIT: regs_q.wr_wait <= cfg_wdata;
            endcase
        end
    end

    // Read-back mux, no extra cycle
    always_comb begin
        case (cfg_addr)
            sram_ctrl_pkg::CFG_WR_WAIT: cfg_rdata = regs_q.wr_wait;
            default: cfg_rdata = regs_q.rd_wait;
        endcase
    end

    assign timing = regs_q;

endmodule

// ==== hdl/sram_ctrl_pkg.sv ====
package sram_ctrl_pkg;

    // SRAM geometry
    localparam int ADDR_W = 15;
    localparam int DATA_W = 16;

    // Wait-state counts
    localparam int WAIT_W = 4;
    localparam logic [WAIT_W-1:0] RD_WAIT_RST = 4'd2;
    localparam logic [WAIT_W-1:0] WR_WAIT_RST = 4'd3;

    // Config register map
    localparam logic CFG_RD_WAIT = 1'b0;
    localparam logic CFG_WR_WAIT = 1'b1;

    typedef struct packed {
        logic [WAIT_W-1:0] rd_wait;
        logic [WAIT_W-1:0] wr_wait;
    } sram_timing_t;

    typedef enum logic [2:0] {
        IDLE,
        RD_SETUP,
        RD_WAIT,
        RD_CAPTURE,
        WR_SETUP,
        WR_PULSE,
        WR_HOLD
    } access_state_t;

    typedef struct packed {
        logic latch_addr;
        logic latch_data;
        logic latch_read;
        logic drive_data_en;
        logic ce_n;
        logic oe_n;
        logic we_n;
    } sram_ctl_t;

endpackage
